// ==== exec_core.f ====
rtl/exec_pkg.sv
rtl/flow_pkg.sv
rtl/issue_queue.sv
rtl/alu_unit.sv
rtl/div_unit.sv
rtl/result_merge.sv
rtl/exec_core.sv
test/exec_core_assert.sv
test/tb_exec_core.sv

// ==== rtl/alu_unit.sv ====
// ------------------------------
// one result register; held until taken
// ------------------------------
`timescale 1ns/1ps

module alu_unit
    import exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       alu_valid_i,
    input  exec_req_t  alu_req_i,
    input  logic       alu_take_i,
    output logic       alu_ready_o,
    output logic       alu_rsp_valid_o,
    output exec_rsp_t  alu_rsp_o
);

    logic [XLEN-1:0]     res;
    logic [SHAMT_W-1:0]  shamt;
    logic                move;

    assign shamt = alu_req_i.src2[SHAMT_W-1:0];

    always_comb begin
        case (alu_req_i.op)
            OP_ADD:  res = alu_req_i.src1 + alu_req_i.src2;
            OP_SUB:  res = alu_req_i.src1 - alu_req_i.src2;
            OP_AND:  res = alu_req_i.src1 & alu_req_i.src2;
            OP_OR:   res = alu_req_i.src1 | alu_req_i.src2;
            OP_XOR:  res = alu_req_i.src1 ^ alu_req_i.src2;
            OP_SLL:  res = alu_req_i.src1 << shamt;
            OP_SRL:  res = alu_req_i.src1 >> shamt;
            OP_SRA:  res = $unsigned($signed(alu_req_i.src1) >>> shamt);
            OP_SLT:  res = XLEN'($signed(alu_req_i.src1) < $signed(alu_req_i.src2));
            OP_SLTU: res = XLEN'(alu_req_i.src1 < alu_req_i.src2);
            // divide ops never reach this unit
            default: res = '0;
        endcase
    end

    // free slot, or the held result leaves this cycle
    assign alu_ready_o = !alu_rsp_valid_o || alu_take_i;
    assign move        = alu_valid_i && alu_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_rsp_valid_o <= 1'b0;
        end else if (move) begin
            alu_rsp_valid_o <= 1'b1;
        end else if (alu_take_i) begin
            alu_rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (move) begin
            alu_rsp_o.result <= res;
            alu_rsp_o.rd     <= alu_req_i.rd;
        end
    end

endmodule

// ==== rtl/div_unit.sv ====
// ------------------------------
// div_start_i is ignored unless idle; result after DIV_STEPS+1 cycles
// ------------------------------
`timescale 1ns/1ps

module div_unit
    import exec_pkg::*;
    import flow_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       div_start_i,
    input  exec_req_t  div_req_i,
    input  logic       div_take_i,
    output logic       div_busy_o,
    output logic       div_rsp_valid_o,
    output exec_rsp_t  div_rsp_o
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e              state;
    logic [DIV_CNT_W-1:0]    cnt;
    logic [XLEN-1:0]         quot;
    logic [XLEN-1:0]         rem;
    logic [XLEN-1:0]         dvsr;
    logic                    quot_neg;
    logic                    rem_neg;
    logic                    want_rem;
    logic [REG_ADDR_W-1:0]   rd_tag;

    logic                    is_signed;
    logic [XLEN-1:0]         src1_mag;
    logic [XLEN-1:0]         src2_mag;
    logic [XLEN:0]           diff;
    logic [XLEN-1:0]         quot_nxt;
    logic [XLEN-1:0]         rem_nxt;
    logic [XLEN-1:0]         quot_fix;
    logic [XLEN-1:0]         rem_fix;
    logic                    last_step;

    assign is_signed = (div_req_i.op == OP_DIV) || (div_req_i.op == OP_REM);
    assign src1_mag  = (is_signed && div_req_i.src1[XLEN-1]) ? -div_req_i.src1 : div_req_i.src1;
    assign src2_mag  = (is_signed && div_req_i.src2[XLEN-1]) ? -div_req_i.src2 : div_req_i.src2;

    // ------------------------------
    // restoring step
    // ------------------------------
    assign diff     = {rem, quot[XLEN-1]} - {1'b0, dvsr};
    assign quot_nxt = {quot[XLEN-2:0], ~diff[XLEN]};
    assign rem_nxt  = diff[XLEN] ? {rem[XLEN-2:0], quot[XLEN-1]} : diff[XLEN-1:0];
    assign quot_fix = quot_neg ? -quot_nxt : quot_nxt;
    assign rem_fix  = rem_neg ? -rem_nxt : rem_nxt;

    assign last_step = (cnt == DIV_CNT_W'(DIV_STEPS - 1));

    assign div_busy_o      = (state != DIV_IDLE);
    assign div_rsp_valid_o = (state == DIV_DONE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (div_start_i) begin
                        state <= DIV_RUN;
                        cnt   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (div_take_i) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == DIV_IDLE && div_start_i) begin
            quot     <= src1_mag;
            rem      <= '0;
            dvsr     <= src2_mag;
            // divide by zero: unsigned all ones quotient, remainder is the dividend
            quot_neg <= is_signed && (div_req_i.src1[XLEN-1] ^ div_req_i.src2[XLEN-1])
                        && (div_req_i.src2 != '0);
            rem_neg  <= is_signed && div_req_i.src1[XLEN-1];
            want_rem <= (div_req_i.op == OP_REM) || (div_req_i.op == OP_REMU);
            rd_tag   <= div_req_i.rd;
        end else if (state == DIV_RUN) begin
            quot <= quot_nxt;
            rem  <= rem_nxt;
            // min / -1 wraps back to min with zero remainder on its own
            if (last_step) begin
                div_rsp_o.result <= want_rem ? rem_fix : quot_fix;
                div_rsp_o.rd     <= rd_tag;
            end
        end
    end

endmodule

// ==== rtl/exec_core.sv ====
// ------------------------------
// issue credits start at ISSUE_DEPTH, response credits at RSP_CREDITS
// ------------------------------
`timescale 1ns/1ps

module exec_core
    import exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       req_valid_i,
    input  exec_req_t  req_i,
    output logic       issue_credit_o,
    input  logic       rsp_credit_i,
    output logic       rsp_valid_o,
    output exec_rsp_t  rsp_o
);

    // queue to units
    logic       alu_valid;
    exec_req_t  alu_req;
    logic       alu_ready;
    logic       div_start;
    exec_req_t  div_req;
    logic       div_busy;

    // units to merge
    logic       alu_rsp_valid;
    exec_rsp_t  alu_rsp;
    logic       div_rsp_valid;
    exec_rsp_t  div_rsp;
    logic       alu_take;
    logic       div_take;

    issue_queue u_issue_queue_0 (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .req_valid_i     ( req_valid_i    ),
        .req_i           ( req_i          ),
        .issue_credit_o  ( issue_credit_o ),
        .alu_ready_i     ( alu_ready      ),
        .div_busy_i      ( div_busy       ),
        .alu_rsp_valid_i ( alu_rsp_valid  ),
        .alu_valid_o     ( alu_valid      ),
        .alu_req_o       ( alu_req        ),
        .div_start_o     ( div_start      ),
        .div_req_o       ( div_req        )
    );

    alu_unit u_alu_unit_0 (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .alu_valid_i     ( alu_valid      ),
        .alu_req_i       ( alu_req        ),
        .alu_take_i      ( alu_take       ),
        .alu_ready_o     ( alu_ready      ),
        .alu_rsp_valid_o ( alu_rsp_valid  ),
        .alu_rsp_o       ( alu_rsp        )
    );

    div_unit u_div_unit_0 (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .div_start_i     ( div_start      ),
        .div_req_i       ( div_req        ),
        .div_take_i      ( div_take       ),
        .div_busy_o      ( div_busy       ),
        .div_rsp_valid_o ( div_rsp_valid  ),
        .div_rsp_o       ( div_rsp        )
    );

    result_merge u_result_merge_0 (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .alu_rsp_valid_i ( alu_rsp_valid  ),
        .alu_rsp_i       ( alu_rsp        ),
        .div_rsp_valid_i ( div_rsp_valid  ),
        .div_rsp_i       ( div_rsp        ),
        .rsp_credit_i    ( rsp_credit_i   ),
        .alu_take_o      ( alu_take       ),
        .div_take_o      ( div_take       ),
        .rsp_valid_o     ( rsp_valid_o    ),
        .rsp_o           ( rsp_o          )
    );

endmodule

// ==== rtl/exec_pkg.sv ====
// ------------------------------
// operands arrive already read; rd is a tag only
// ------------------------------
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // shift amount bits taken from src2
    localparam int SHAMT_W    = 5;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } exec_op_e;

    typedef struct packed {
        exec_op_e               op;
        logic [XLEN-1:0]        src1;
        logic [XLEN-1:0]        src2;
        logic [REG_ADDR_W-1:0]  rd;
    } exec_req_t;

    typedef struct packed {
        logic [XLEN-1:0]        result;
        logic [REG_ADDR_W-1:0]  rd;
    } exec_rsp_t;

    // ops served by the iterative divider
    function automatic logic is_div_op(exec_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    endfunction

endpackage

// ==== rtl/flow_pkg.sv ====
// ------------------------------
// ISSUE_DEPTH must be a power of two
// ------------------------------
package flow_pkg;

    // queue entries, also the issuer's starting credits
    localparam int ISSUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(ISSUE_DEPTH);

    // responses in flight before a credit comes back
    localparam int RSP_CREDITS = 2;

    // holds 0..ISSUE_DEPTH and 0..RSP_CREDITS
    localparam int CREDIT_W    = 3;

    // one quotient bit per iteration
    localparam int DIV_STEPS   = 32;
    localparam int DIV_CNT_W   = $clog2(DIV_STEPS);

endpackage

// ==== rtl/issue_queue.sv ====
// ------------------------------
// issuer must hold a credit for each push; no overflow check here
// ------------------------------
`timescale 1ns/1ps

module issue_queue
    import exec_pkg::*;
    import flow_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       req_valid_i,
    input  exec_req_t  req_i,
    output logic       issue_credit_o,
    input  logic       alu_ready_i,
    input  logic       div_busy_i,
    input  logic       alu_rsp_valid_i,
    output logic       alu_valid_o,
    output exec_req_t  alu_req_o,
    output logic       div_start_o,
    output exec_req_t  div_req_o
);

    exec_req_t             entries [ISSUE_DEPTH];
    logic [QPTR_W-1:0]     wr_ptr;
    logic [QPTR_W-1:0]     rd_ptr;
    logic [CREDIT_W-1:0]   count;
    logic                  empty;
    logic                  head_is_div;
    logic                  pop;
    exec_req_t             head;

    assign empty       = (count == '0);
    assign head        = entries[rd_ptr];
    assign head_is_div = is_div_op(head.op);

    // ------------------------------
    // dispatch
    // ------------------------------
    // nothing leaves while the divider is busy, so results stay in order
    assign alu_valid_o = !empty && !head_is_div && !div_busy_i;
    // a divide waits until the ALU result has drained
    assign div_start_o = !empty && head_is_div && !div_busy_i && !alu_rsp_valid_i;

    assign alu_req_o = head;
    assign div_req_o = head;

    assign pop            = (alu_valid_o && alu_ready_i) || div_start_o;
    assign issue_credit_o = pop;

    // ------------------------------
    // storage and pointers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            entries[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/result_merge.sv ====
// ------------------------------
// expects at most one unit to hold a result at a time
// ------------------------------
`timescale 1ns/1ps

module result_merge
    import exec_pkg::*;
    import flow_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       alu_rsp_valid_i,
    input  exec_rsp_t  alu_rsp_i,
    input  logic       div_rsp_valid_i,
    input  exec_rsp_t  div_rsp_i,
    input  logic       rsp_credit_i,
    output logic       alu_take_o,
    output logic       div_take_o,
    output logic       rsp_valid_o,
    output exec_rsp_t  rsp_o
);

    logic [CREDIT_W-1:0]  credit_cnt;
    logic                 have_credit;
    logic                 send;

    assign have_credit = (credit_cnt != '0);

    // divider first; it would be the older result
    assign div_take_o = div_rsp_valid_i && have_credit;
    assign alu_take_o = alu_rsp_valid_i && have_credit && !div_rsp_valid_i;
    assign send       = alu_take_o || div_take_o;

    // ------------------------------
    // response credits
    // ------------------------------
    // spent at the take, one cycle before rsp_valid_o
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CREDIT_W'(RSP_CREDITS);
        end else begin
            case ({send, rsp_credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= send;
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_take_o) begin
            rsp_o <= div_rsp_i;
        end else if (alu_take_o) begin
            rsp_o <= alu_rsp_i;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_exec_core -f exec_core.f -o sim_exec_core \
    && ./obj_dir/sim_exec_core | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/exec_core_assert.sv ====
// ------------------------------
// one checker, bound twice; unused inputs are tied off at each bind
// ------------------------------
`timescale 1ns/1ps

module exec_core_assert
    import flow_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 rsp_valid_i,
    input  logic                 rsp_credit_i,
    input  logic [CREDIT_W-1:0]  credit_cnt_i,
    input  logic                 alu_held_i,
    input  logic                 div_busy_i
);

    // responses on the bus not yet paid back by the consumer
    logic [CREDIT_W-1:0]  in_flight;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_flight <= '0;
        end else begin
            case ({rsp_valid_i, rsp_credit_i})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    no_send_without_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> (in_flight < CREDIT_W'(RSP_CREDITS)))
        else $error("response sent with no response credit left");

    credit_cnt_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt_i <= CREDIT_W'(RSP_CREDITS))
        else $error("response credit counter above its starting value");

    // at most one unit holds an untaken result, so responses stay in order
    one_result_holder: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(alu_held_i && div_busy_i))
        else $error("ALU result held while the divider was busy");

endmodule

bind result_merge exec_core_assert merge_checks (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .rsp_valid_i  ( rsp_valid_o  ),
    .rsp_credit_i ( rsp_credit_i ),
    .credit_cnt_i ( credit_cnt   ),
    .alu_held_i   ( 1'b0         ),
    .div_busy_i   ( 1'b0         )
);

bind issue_queue exec_core_assert queue_checks (
    .clk_i        ( clk_i           ),
    .rst_n_i      ( rst_n_i         ),
    .rsp_valid_i  ( 1'b0            ),
    .rsp_credit_i ( 1'b0            ),
    .credit_cnt_i ( '0              ),
    .alu_held_i   ( alu_rsp_valid_i ),
    .div_busy_i   ( div_busy_i      )
);

// ==== test/tb_exec_core.sv ====
// ------------------------------
// in-order reference model; the consumer returns one credit per cycle unless held
// ------------------------------
`timescale 1ns/1ps

module tb_exec_core
    import exec_pkg::*;
    import flow_pkg::*;
();

    localparam int N_ALU      = 40;
    localparam int N_DIV_EDGE = 8;
    localparam int N_DIV_RAND = 8;
    localparam int N_MIX      = 30;
    localparam int N_HOLD     = 6;
    localparam int N_REQ      = N_ALU + N_DIV_EDGE + N_DIV_RAND + N_MIX + N_HOLD;
    localparam int WATCH_CYCLES = N_REQ * (DIV_STEPS + 10) + 300;

    logic       clk_i;
    logic       rst_n_i;
    logic       req_valid_i;
    exec_req_t  req_i;
    logic       issue_credit_o;
    logic       rsp_credit_i = 1'b0;
    logic       rsp_valid_o;
    exec_rsp_t  rsp_o;

    int         seed;
    int         errors;
    int         sent;
    int         rsp_count;
    int         credit_pulses;
    int         credits_returned;
    int         rsp_before;
    logic       hold_credits;
    exec_rsp_t  exp_q [$];
    exec_rsp_t  exp_head;

    always #4 clk_i = ~clk_i;

    exec_core dut0 (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .req_valid_i    ( req_valid_i    ),
        .req_i          ( req_i          ),
        .issue_credit_o ( issue_credit_o ),
        .rsp_credit_i   ( rsp_credit_i   ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_o          ( rsp_o          )
    );

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [XLEN-1:0] ref_exec(exec_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        int               sa;
        int               sb;
        logic [4:0]       sh;
        logic [XLEN-1:0]  r;
        sa = a;
        sb = b;
        sh = b[4:0];
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = a >> sh;
            OP_SRA:  r = sa >>> sh;
            OP_SLT:  r = (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            OP_DIV: begin
                if (b == 0) begin
                    r = '1;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    r = a;
                end else begin
                    r = sa / sb;
                end
            end
            OP_DIVU: r = (b == 0) ? '1 : a / b;
            OP_REM: begin
                if (b == 0) begin
                    r = a;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    r = '0;
                end else begin
                    r = sa % sb;
                end
            end
            OP_REMU: r = (b == 0) ? a : a % b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // ------------------------------
    // issuer
    // ------------------------------
    task automatic send_req(input exec_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] rd);
        exec_rsp_t exp_rsp;
        @(posedge clk_i);
        #1;
        // out of issue credits
        while (sent - credit_pulses >= ISSUE_DEPTH) begin
            req_valid_i = 1'b0;
            @(posedge clk_i);
            #1;
        end
        req_i.op    = op;
        req_i.src1  = a;
        req_i.src2  = b;
        req_i.rd    = rd;
        req_valid_i = 1'b1;
        sent++;
        exp_rsp.result = ref_exec(op, a, b);
        exp_rsp.rd     = rd;
        exp_q.push_back(exp_rsp);
    endtask

    task automatic send_random(input logic div_class);
        logic [31:0]      pick;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        pick = $random(seed);
        a    = $random(seed);
        b    = $random(seed);
        if (div_class) begin
            send_req(exec_op_e'(4'(OP_DIV) + 4'(pick % 4)), a, b, REG_ADDR_W'(pick >> 8));
        end else begin
            // the ten ALU ops come first in the enum
            send_req(exec_op_e'(4'(pick % 10)), a, b, REG_ADDR_W'(pick >> 8));
        end
    endtask

    task automatic end_burst();
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic drain_responses(input int max_cycles);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || rsp_count != credits_returned) && n < max_cycles) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses still missing after %0d cycles", exp_q.size(), n);
        end
    endtask

    // ------------------------------
    // consumer and compare
    // ------------------------------
    always @(posedge clk_i) begin
        #1;
        if (rst_n_i && !hold_credits && rsp_count > credits_returned) begin
            rsp_credit_i = 1'b1;
            credits_returned++;
        end else begin
            rsp_credit_i = 1'b0;
        end
    end

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (issue_credit_o) begin
                credit_pulses++;
                if (credit_pulses > sent) begin
                    errors++;
                    $display("issue credit returned at %0t with no request outstanding", $time);
                end
            end
            if (rsp_valid_o) begin
                rsp_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response at %0t with no request outstanding", $time);
                end else begin
                    exp_head = exp_q.pop_front();
                    check_value("rsp_o.result", exp_head.result, rsp_o.result);
                    check_value("rsp_o.rd", 32'(exp_head.rd), 32'(rsp_o.rd));
                end
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk_i);
        $display("timeout: traffic did not finish within %0d cycles", WATCH_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed = 32'h5053f774;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        hold_credits = 1'b0;
        errors = 0;
        sent = 0;
        rsp_count = 0;
        credit_pulses = 0;
        credits_returned = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // quiet until the first request
        repeat (5) begin
            @(negedge clk_i);
            check_value("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
            check_value("issue_credit_o", 32'd0, 32'(issue_credit_o));
        end

        for (int i = 0; i < N_ALU; i++) begin
            send_random(1'b0);
        end
        end_burst();
        drain_responses(WATCH_CYCLES);

        // divide by zero, overflow, mixed signs
        send_req(OP_DIV, 32'h1234_5678, 32'h0, 5'd1);
        send_req(OP_DIVU, 32'hdead_beef, 32'h0, 5'd2);
        send_req(OP_REM, 32'h8000_0001, 32'h0, 5'd3);
        send_req(OP_REMU, 32'h0000_0007, 32'h0, 5'd4);
        send_req(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 5'd5);
        send_req(OP_REM, 32'h8000_0000, 32'hffff_ffff, 5'd6);
        send_req(OP_DIV, 32'hffff_fff9, 32'h0000_0002, 5'd7);
        send_req(OP_REM, 32'hffff_fff9, 32'h0000_0002, 5'd8);
        for (int i = 0; i < N_DIV_RAND; i++) begin
            send_random(1'b1);
        end
        end_burst();
        drain_responses(WATCH_CYCLES);

        for (int i = 0; i < N_MIX; i++) begin
            send_random(($unsigned($random(seed)) % 4) == 0);
        end
        end_burst();
        drain_responses(WATCH_CYCLES);

        // response credits withheld
        repeat (2) @(posedge clk_i);
        hold_credits = 1'b1;
        rsp_before = rsp_count;
        for (int i = 0; i < N_HOLD; i++) begin
            send_random(1'b0);
        end
        end_burst();
        repeat (40) @(posedge clk_i);
        check_value("responses while credits held", RSP_CREDITS, rsp_count - rsp_before);
        hold_credits = 1'b0;
        drain_responses(WATCH_CYCLES);

        repeat (5) @(posedge clk_i);
        check_value("issue_credit_o pulses", sent, credit_pulses);
        check_value("responses received", sent, rsp_count);

        $display("checks done: %0d errors, %0d requests, %0d responses, %0d issue credits",
                 errors, sent, rsp_count, credit_pulses);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
